// ==== test/icache_stim.txt ====
# op: T starts a test (id, expected strobes), F fetch (address, parcel), X flush
# address and parcel columns are hex; parcel = address ^ 5A5A0000
T 4 2
F 00004030 5A5A4030
F 00005030 5A5A5030
F 00004034 5A5A4034
F 00005038 5A5A5038
T 1 1
F 00001008 5A5A1008
T 2 0
F 00001000 5A5A1000
F 00001004 5A5A1004
F 0000100C 5A5A100C
T 3 2
F 00002010 5A5A2010
F 00002014 5A5A2014
F 00003020 5A5A3020
F 00003024 5A5A3024
T 5 1
X 00000000 00000000
F 00001008 5A5A1008
F 00001000 5A5A1000

// ==== sources.f ====
rtl/biu_pkg.sv
rtl/icache_pkg.sv
rtl/icache_setup.sv
rtl/icache_memory.sv
rtl/icache_hit.sv
rtl/icache_biu_ctrl.sv
rtl/icache_core.sv
test/tb_icache.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_icache
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_icache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Simulation finished: PASS$"; then
  exit 0
fi
exit 1

// ==== test/tb_icache.sv ====
// ----------------------------------------
// Instruction cache core testbench
// Stim file fetches, bus slave, parcel checks
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

module tb_icache;

  localparam int STB_WAIT = 4;            // Slave cycles before taking the strobe
  localparam int BEATS    = 4;

  logic        clk_i, rst_ni;
  logic        mem_req_i, mem_ack_o, parcel_valid_o, cache_flush_i;
  logic [31:0] mem_adr_i, parcel_o;
  logic        biu_stb_o, biu_stb_ack_i, biu_ack_i;
  logic [31:0] biu_adri_o, biu_q_i;

  string       op_q[$];                   // Stim file contents
  logic [31:0] adr_q[$];
  logic [31:0] dat_q[$];
  logic [31:0] exp_q[$];                  // Parcels still to come
  logic [31:0] fetch_adr_q[$];            // Fetch addresses of those parcels
  int          n_ops, errors, tests_run, tests_failed;
  int          stb_total, stb_base, test_id, exp_strobes, test_err0;
  logic        stb_prev;

  icache_core u_icache_core (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .mem_req_i      ( mem_req_i      ),
    .mem_adr_i      ( mem_adr_i      ),
    .mem_ack_o      ( mem_ack_o      ),
    .parcel_o       ( parcel_o       ),
    .parcel_valid_o ( parcel_valid_o ),
    .cache_flush_i  ( cache_flush_i  ),
    .biu_stb_o      ( biu_stb_o      ),
    .biu_stb_ack_i  ( biu_stb_ack_i  ),
    .biu_adri_o     ( biu_adri_o     ),
    .biu_q_i        ( biu_q_i        ),
    .biu_ack_i      ( biu_ack_i      )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Bus slave and strobe monitor
  // ----------------------------------------
  initial begin
    logic [31:0] line_adr;
    forever begin
      @(negedge clk_i);
      if (rst_ni && biu_stb_o) begin
        line_adr = biu_adri_o;
        repeat (STB_WAIT) @(negedge clk_i);
        biu_stb_ack_i = 1'b1;
        @(negedge clk_i);
        biu_stb_ack_i = 1'b0;
        for (int i = 0; i < BEATS; i++) begin
          biu_ack_i = 1'b1;
          biu_q_i   = (line_adr + 32'(4 * i)) ^ 32'h5A5A_0000;  // Memory contents rule
          @(negedge clk_i);
        end
        biu_ack_i = 1'b0;
      end
    end
  end

  // Burst must fetch the line of the oldest open fetch
  always @(negedge clk_i) begin
    logic [31:0] line_exp;
    if (rst_ni && biu_stb_o && !stb_prev) begin
      stb_total++;
      assert (fetch_adr_q.size() != 0) else begin
        $display("%0t burst started with no fetch outstanding", $time);
        errors++;
      end
      if (fetch_adr_q.size() != 0) begin
        line_exp = {fetch_adr_q[0][31:4], 4'h0};
        assert (biu_adri_o == line_exp) else begin
          $display("[ERROR] %0t biu_adri_o: got %h, expected %h", $time, biu_adri_o,
                   line_exp);
          errors++;
        end
      end
    end
    stb_prev <= biu_stb_o;
  end

  // Parcels must arrive in request order
  always @(negedge clk_i) begin
    logic [31:0] exp;
    if (rst_ni && parcel_valid_o) begin
      assert (exp_q.size() != 0) else begin
        $display("%0t parcel delivered with no fetch outstanding", $time);
        errors++;
      end
      if (exp_q.size() != 0) begin
        exp = exp_q.pop_front();
        void'(fetch_adr_q.pop_front());
        assert (parcel_o == exp) else begin
          $display("[ERROR] %0t parcel_o: got %h, expected %h", $time, parcel_o, exp);
          errors++;
        end
      end
    end
  end

  // ----------------------------------------
  // Stimulus tasks
  // ----------------------------------------
  task automatic load_stim();
    int    fd, code;
    string line, op;
    logic [31:0] a, d;
    fd = $fopen("test/icache_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stim file");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      code = $sscanf(line, "%s %h %h", op, a, d);
      if (code != 3) continue;
      op_q.push_back(op);
      adr_q.push_back(a);
      dat_q.push_back(d);
    end
    $fclose(fd);
    n_ops = op_q.size();
  endtask

  task automatic fetch_word(input logic [31:0] a, input logic [31:0] e);
    @(negedge clk_i);
    mem_req_i = 1'b1;
    mem_adr_i = a;
    #1;
    while (!mem_ack_o) begin          // Held through a miss or flush
      @(negedge clk_i);
      #1;
    end
    exp_q.push_back(e);               // Taken at the coming rising edge
    fetch_adr_q.push_back(a);
  endtask

  task automatic drain();
    @(negedge clk_i);
    mem_req_i = 1'b0;
    while (exp_q.size() != 0) @(negedge clk_i);
  endtask

  task automatic flush_cache();
    drain();
    cache_flush_i = 1'b1;
    @(negedge clk_i);
    cache_flush_i = 1'b0;
    while (mem_ack_o) @(negedge clk_i);
    while (!mem_ack_o) @(negedge clk_i);  // Set walk done
  endtask

  task automatic close_test();
    int strobes;
    drain();
    repeat (2) @(negedge clk_i);      // Catch stray parcels
    strobes = stb_total - stb_base;
    assert (strobes == exp_strobes) else begin
      $display("[ERROR] %0t biu_stb_o rising edges: got %0d, expected %0d", $time,
               strobes, exp_strobes);
      errors++;
    end
    tests_run++;
    if (errors != test_err0) tests_failed++;
    $display("test %0d: %s, %0d strobes", test_id,
             (errors == test_err0) ? "ok" : "FAILED", strobes);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    mem_req_i     = 1'b0;
    mem_adr_i     = '0;
    cache_flush_i = 1'b0;
    biu_stb_ack_i = 1'b0;
    biu_ack_i     = 1'b0;
    biu_q_i       = '0;
    stb_prev      = 1'b0;
    rst_ni        = 1'b0;
    load_stim();
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    // Idle outputs straight out of reset
    assert (mem_ack_o && !biu_stb_o && !parcel_valid_o) else begin
      $display("%0t outputs not idle after reset", $time);
      errors++;
    end
    test_id = -1;
    if (n_ops == 0) begin
      $display("stim file holds no operations");
      errors++;
    end
    for (int i = 0; i < n_ops; i++) begin
      case (op_q[i])
        "T": begin
          if (test_id >= 0) close_test();
          test_id     = int'(adr_q[i]);
          exp_strobes = int'(dat_q[i]);
          stb_base    = stb_total;
          test_err0   = errors;
        end
        "F": fetch_word(adr_q[i], dat_q[i]);
        "X": flush_cache();
        default: begin
          $display("unknown operation in the stim file");
          errors++;
        end
      endcase
    end
    if (test_id >= 0) close_test();
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog, 200 cycles per stim line
  initial begin
    wait (n_ops != 0);
    repeat (200 * n_ops + 40) @(posedge clk_i);
    $display("watchdog expired before the tests completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule : tb_icache

`default_nettype wire

// ==== rtl/icache_core.sv ====
// ----------------------------------------
// Instruction cache core
// Setup, memory, hit stage and bus controller
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

module icache_core
  import icache_pkg::*;
  import biu_pkg::*;
#(
  parameter int WAYS      = 2,   // Associativity
  parameter int SETS      = 4,   // Power of two
  parameter int BURST_LEN = 4    // Words per block
) (
  input  wire              clk_i,
  input  wire              rst_ni,

  // CPU side
  input  wire              mem_req_i,
  input  wire  [PLEN -1:0] mem_adr_i,
  output logic             mem_ack_o,
  output logic [XLEN -1:0] parcel_o,
  output logic             parcel_valid_o,
  input  wire              cache_flush_i,   // Invalidate all lines

  // Bus side
  output logic             biu_stb_o,
  input  wire              biu_stb_ack_i,
  output logic [PLEN -1:0] biu_adri_o,
  input  wire  [XLEN -1:0] biu_q_i,
  input  wire              biu_ack_i
);

  localparam int IDX_BITS      = $clog2(SETS);
  localparam int BLK_OFFS_BITS = $clog2(BURST_LEN * XLEN / 8);
  localparam int TAG_BITS      = PLEN - IDX_BITS - BLK_OFFS_BITS;
  localparam int BLK_BITS      = BURST_LEN * XLEN;

  logic                stall;
  logic                setup_req;
  logic [PLEN    -1:0] setup_adr;
  logic [IDX_BITS-1:0] setup_idx;
  logic                cache_hit;
  logic [BLK_BITS-1:0] cache_line;
  logic                filling, flushing;
  logic [IDX_BITS-1:0] wr_idx;
  logic [TAG_BITS-1:0] wr_tag;
  biucmd_t             biucmd;
  logic [PLEN    -1:0] miss_adr;
  logic                biucmd_ack;
  logic [BLK_BITS-1:0] biu_line;
  logic                cacheflush_pending;

  assign mem_ack_o = ~stall;

  // Flush request held until the hit stage starts it
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) cacheflush_pending <= 1'b0;
    else         cacheflush_pending <= cache_flush_i | (cacheflush_pending & ~flushing);
  end

  // ----------------------------------------
  // Pipeline
  // ----------------------------------------
  icache_setup #(
    .SETS      ( SETS      ),
    .BURST_LEN ( BURST_LEN )
  ) u_setup (
    .clk_i    ( clk_i     ),
    .rst_ni   ( rst_ni    ),
    .stall_i  ( stall     ),
    .req_i    ( mem_req_i ),
    .adr_i    ( mem_adr_i ),
    .req_o    ( setup_req ),
    .adr_o    ( setup_adr ),
    .rd_idx_o ( setup_idx )
  );

  icache_memory #(
    .WAYS      ( WAYS      ),
    .SETS      ( SETS      ),
    .BURST_LEN ( BURST_LEN )
  ) u_memory (
    .clk_i        ( clk_i                          ),
    .rst_ni       ( rst_ni                         ),
    .rd_idx_i     ( setup_idx                      ),
    .rd_tag_i     ( setup_adr[PLEN-1 -: TAG_BITS]  ),
    .filling_i    ( filling                        ),
    .flushing_i   ( flushing                       ),
    .wr_idx_i     ( wr_idx                         ),
    .wr_tag_i     ( wr_tag                         ),
    .biu_line_i   ( biu_line                       ),
    .hit_o        ( cache_hit                      ),
    .cache_line_o ( cache_line                     )
  );

  icache_hit #(
    .SETS      ( SETS      ),
    .BURST_LEN ( BURST_LEN )
  ) u_hit (
    .clk_i            ( clk_i              ),
    .rst_ni           ( rst_ni             ),
    .req_i            ( setup_req          ),
    .adr_i            ( setup_adr          ),
    .cache_hit_i      ( cache_hit          ),
    .cache_line_i     ( cache_line         ),
    .cacheflush_req_i ( cacheflush_pending ),
    .biucmd_o         ( biucmd             ),
    .miss_adr_o       ( miss_adr           ),
    .biucmd_ack_i     ( biucmd_ack         ),
    .biu_line_i       ( biu_line           ),
    .stall_o          ( stall              ),
    .filling_o        ( filling            ),
    .flushing_o       ( flushing           ),
    .wr_idx_o         ( wr_idx             ),
    .wr_tag_o         ( wr_tag             ),
    .parcel_o         ( parcel_o           ),
    .parcel_valid_o   ( parcel_valid_o     )
  );

  // ----------------------------------------
  // Bus interface
  // ----------------------------------------
  icache_biu_ctrl #(
    .BURST_LEN ( BURST_LEN )
  ) u_biu_ctrl (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .biucmd_i      ( biucmd        ),
    .miss_adr_i    ( miss_adr      ),
    .biucmd_ack_o  ( biucmd_ack    ),
    .biu_line_o    ( biu_line      ),
    .biu_stb_o     ( biu_stb_o     ),
    .biu_stb_ack_i ( biu_stb_ack_i ),
    .biu_adri_o    ( biu_adri_o    ),
    .biu_q_i       ( biu_q_i       ),
    .biu_ack_i     ( biu_ack_i     )
  );

endmodule : icache_core

`default_nettype wire

// ==== rtl/icache_biu_ctrl.sv ====
// ----------------------------------------
// Instruction cache bus controller
// Burst line read, assembles the fetched block
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

module icache_biu_ctrl
  import icache_pkg::*;
  import biu_pkg::*;
#(
  parameter int BURST_LEN = 4
) (
  input  wire                        clk_i,
  input  wire                        rst_ni,
  input  wire biucmd_t               biucmd_i,
  input  wire  [PLEN           -1:0] miss_adr_i,
  output logic                       biucmd_ack_o,  // Line complete
  output logic [BURST_LEN*XLEN -1:0] biu_line_o,
  output logic                       biu_stb_o,
  input  wire                        biu_stb_ack_i,
  output logic [PLEN           -1:0] biu_adri_o,
  input  wire  [XLEN           -1:0] biu_q_i,
  input  wire                        biu_ack_i
);

  localparam int BLK_OFFS_BITS = $clog2(BURST_LEN * XLEN / 8);
  localparam int BLK_BITS      = BURST_LEN * XLEN;
  localparam int CNT_BITS      = $clog2(BURST_LEN);

  biu_state_t          state;
  logic [CNT_BITS-1:0] ack_cnt;   // Beats received

  // ----------------------------------------
  // Burst FSM
  // ----------------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state        <= IDLE;
      biu_stb_o    <= 1'b0;
      biucmd_ack_o <= 1'b0;
      ack_cnt      <= '0;
    end else begin
      biucmd_ack_o <= 1'b0;
      case (state)
        IDLE: if (biucmd_i == READ_LINE) begin
          biu_stb_o <= 1'b1;
          ack_cnt   <= '0;
          state     <= WAIT_STB;
        end
        WAIT_STB: if (biu_stb_ack_i) begin  // Address taken
          biu_stb_o <= 1'b0;
          state     <= BURST;
        end
        BURST: if (biu_ack_i) begin
          ack_cnt <= ack_cnt + 1'b1;
          if (ack_cnt == CNT_BITS'(BURST_LEN - 1)) begin
            biucmd_ack_o <= 1'b1;
            state        <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Line-aligned start address, loaded with the strobe
  always_ff @(posedge clk_i) begin
    if (state == IDLE && biucmd_i == READ_LINE) begin
      biu_adri_o <= {miss_adr_i[PLEN-1:BLK_OFFS_BITS], {BLK_OFFS_BITS{1'b0}}};
    end
  end

  // Ascending beats shift in from the top, first word ends at bit 0
  always_ff @(posedge clk_i) begin
    if (state == BURST && biu_ack_i) begin
      biu_line_o <= {biu_q_i, biu_line_o[BLK_BITS-1:XLEN]};
    end
  end

endmodule : icache_biu_ctrl

`default_nettype wire

// ==== rtl/icache_hit.sv ====
// ----------------------------------------
// Instruction cache hit stage
// Front-end FSM, miss detect, parcel select, flush
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

module icache_hit
  import icache_pkg::*;
  import biu_pkg::*;
#(
  parameter int SETS      = 4,
  parameter int BURST_LEN = 4
) (
  input  wire                              clk_i,
  input  wire                              rst_ni,
  input  wire                              req_i,         // From setup stage
  input  wire  [PLEN                 -1:0] adr_i,
  input  wire                              cache_hit_i,
  input  wire  [BURST_LEN*XLEN       -1:0] cache_line_i,
  input  wire                              cacheflush_req_i,
  output biucmd_t                          biucmd_o,
  output logic [PLEN                 -1:0] miss_adr_o,
  input  wire                              biucmd_ack_i,
  input  wire  [BURST_LEN*XLEN       -1:0] biu_line_i,
  output logic                             stall_o,
  output logic                             filling_o,
  output logic                             flushing_o,
  output logic [$clog2(SETS)         -1:0] wr_idx_o,
  output logic [PLEN-$clog2(SETS)-$clog2(BURST_LEN*XLEN/8)-1:0] wr_tag_o,
  output logic [XLEN                 -1:0] parcel_o,
  output logic                             parcel_valid_o
);

  localparam int IDX_BITS      = $clog2(SETS);
  localparam int BYTE_BITS     = $clog2(XLEN / 8);
  localparam int DAT_OFFS_BITS = $clog2(BURST_LEN);
  localparam int BLK_OFFS_BITS = BYTE_BITS + DAT_OFFS_BITS;
  localparam int TAG_BITS      = PLEN - IDX_BITS - BLK_OFFS_BITS;

  hit_state_t               state, state_nxt;
  logic                     miss;
  logic [IDX_BITS     -1:0] flush_cnt;
  logic [DAT_OFFS_BITS-1:0] word_sel;

  assign miss     = req_i & ~cache_hit_i;
  assign word_sel = adr_i[BYTE_BITS +: DAT_OFFS_BITS];

  // ----------------------------------------
  // Front-end FSM
  // ----------------------------------------
  always_comb begin
    state_nxt = state;
    biucmd_o  = NOP;
    case (state)
      ARMED: begin
        if (miss) begin                          // Miss wins over flush
          biucmd_o  = READ_LINE;
          state_nxt = WAIT4BIU;
        end else if (cacheflush_req_i) begin
          state_nxt = FLUSH;
        end
      end
      WAIT4BIU: if (biucmd_ack_i) state_nxt = FILL;
      FILL:     state_nxt = ARMED;               // Single write cycle
      FLUSH:    if (flush_cnt == IDX_BITS'(SETS - 1)) state_nxt = ARMED;
      default:  state_nxt = ARMED;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state     <= ARMED;
      flush_cnt <= '0;
    end else begin
      state     <= state_nxt;
      flush_cnt <= (state == FLUSH) ? flush_cnt + 1'b1 : '0;  // Set walker
    end
  end

  // Stall on a miss, the burst wait and the flush walk
  assign stall_o    = (state == ARMED & miss) | (state == WAIT4BIU) | (state == FLUSH);
  assign filling_o  = (state == FILL);
  assign flushing_o = (state == FLUSH);
  assign miss_adr_o = adr_i;                    // Held by the stall

  assign wr_idx_o = flushing_o ? flush_cnt : adr_i[BLK_OFFS_BITS +: IDX_BITS];
  assign wr_tag_o = adr_i[PLEN-1 -: TAG_BITS];

  // ----------------------------------------
  // Parcel output
  // ----------------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) parcel_valid_o <= 1'b0;
    else         parcel_valid_o <= (state == ARMED & req_i & cache_hit_i) | filling_o;
  end

  always_ff @(posedge clk_i) begin
    if (filling_o) parcel_o <= biu_line_i  [word_sel*XLEN +: XLEN];  // Missed word
    else           parcel_o <= cache_line_i[word_sel*XLEN +: XLEN];
  end

endmodule : icache_hit

`default_nettype wire

// ==== rtl/icache_memory.sv ====
// ----------------------------------------
// Instruction cache tag, valid and data arrays
// Hit compare, way mux, random fill way
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

module icache_memory
  import biu_pkg::*;
#(
  parameter int WAYS      = 2,
  parameter int SETS      = 4,
  parameter int BURST_LEN = 4
) (
  input  wire                              clk_i,
  input  wire                              rst_ni,
  input  wire  [$clog2(SETS)         -1:0] rd_idx_i,
  input  wire  [PLEN-$clog2(SETS)-$clog2(BURST_LEN*XLEN/8)-1:0] rd_tag_i,
  input  wire                              filling_i,
  input  wire                              flushing_i,
  input  wire  [$clog2(SETS)         -1:0] wr_idx_i,   // Fill index or flush counter
  input  wire  [PLEN-$clog2(SETS)-$clog2(BURST_LEN*XLEN/8)-1:0] wr_tag_i,
  input  wire  [BURST_LEN*XLEN       -1:0] biu_line_i,
  output logic                             hit_o,
  output logic [BURST_LEN*XLEN       -1:0] cache_line_o
);

  localparam int IDX_BITS      = $clog2(SETS);
  localparam int BLK_OFFS_BITS = $clog2(BURST_LEN * XLEN / 8);
  localparam int TAG_BITS      = PLEN - IDX_BITS - BLK_OFFS_BITS;
  localparam int BLK_BITS      = BURST_LEN * XLEN;
  localparam int WAY_BITS      = (WAYS > 1) ? $clog2(WAYS) : 1;

  logic [TAG_BITS-1:0] tag_mem   [WAYS][SETS];
  logic [BLK_BITS-1:0] dat_mem   [WAYS][SETS];
  logic [WAYS    -1:0] valid_mem [SETS];

  logic [TAG_BITS-1:0] rd_tag_q  [WAYS];  // Synchronous read outputs
  logic [BLK_BITS-1:0] rd_dat_q  [WAYS];
  logic [WAYS    -1:0] rd_val_q;

  logic [6:0]          way_random;
  logic [WAY_BITS-1:0] fill_way;
  logic                same_set;          // Write hits the set being read

  // ----------------------------------------
  // Random replacement
  // ----------------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni)         way_random <= '0;
    else if (!filling_i) way_random <= {way_random[5:0], way_random[6] ~^ way_random[5]};
  end

  assign fill_way = (WAYS == 1) ? '0 : way_random[WAY_BITS-1:0];  // WAYS power of two
  assign same_set = (wr_idx_i == rd_idx_i);

  // ----------------------------------------
  // Arrays
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (filling_i) begin
      tag_mem[fill_way][wr_idx_i] <= wr_tag_i;
      dat_mem[fill_way][wr_idx_i] <= biu_line_i;
    end
    for (int w = 0; w < WAYS; w++) begin
      if (filling_i && same_set && fill_way == WAY_BITS'(w)) begin
        rd_tag_q[w] <= wr_tag_i;     // Forward the line being written
        rd_dat_q[w] <= biu_line_i;
      end else begin
        rd_tag_q[w] <= tag_mem[w][rd_idx_i];
        rd_dat_q[w] <= dat_mem[w][rd_idx_i];
      end
    end
  end

  // Valid bits, cleared by reset and by flush
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < SETS; s++) valid_mem[s] <= '0;
      rd_val_q <= '0;
    end else begin
      if (flushing_i)     valid_mem[wr_idx_i]           <= '0;
      else if (filling_i) valid_mem[wr_idx_i][fill_way] <= 1'b1;
      for (int w = 0; w < WAYS; w++) begin
        if (flushing_i && same_set)                                  rd_val_q[w] <= 1'b0;
        else if (filling_i && same_set && fill_way == WAY_BITS'(w)) rd_val_q[w] <= 1'b1;
        else                                                         rd_val_q[w] <= valid_mem[rd_idx_i][w];
      end
    end
  end

  // ----------------------------------------
  // Tag compare and way mux
  // ----------------------------------------
  always_comb begin
    hit_o        = 1'b0;
    cache_line_o = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (rd_val_q[w] && rd_tag_q[w] == rd_tag_i) begin
        hit_o        = 1'b1;
        cache_line_o = cache_line_o | rd_dat_q[w];  // At most one way hits
      end
    end
  end

endmodule : icache_memory

`default_nettype wire

// ==== rtl/icache_setup.sv ====
// ----------------------------------------
// Instruction cache address setup stage
// Registers fetches, drives the read index
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

module icache_setup
  import biu_pkg::*;
#(
  parameter int SETS      = 4,
  parameter int BURST_LEN = 4
) (
  input  wire                 clk_i,
  input  wire                 rst_ni,
  input  wire                 stall_i,   // Hold stage contents
  input  wire                 req_i,
  input  wire  [PLEN   -1:0]  adr_i,
  output logic                req_o,
  output logic [PLEN   -1:0]  adr_o,
  output logic [$clog2(SETS)-1:0] rd_idx_o
);

  localparam int IDX_BITS      = $clog2(SETS);
  localparam int BLK_OFFS_BITS = $clog2(BURST_LEN * XLEN / 8);

  // Request valid bit
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni)       req_o <= 1'b0;
    else if (!stall_i) req_o <= req_i;
  end

  // Address payload
  always_ff @(posedge clk_i) begin
    if (!stall_i) adr_o <= adr_i;
  end

  // Held address keeps memory output stable during a stall
  assign rd_idx_o = stall_i ? adr_o[BLK_OFFS_BITS +: IDX_BITS]
                            : adr_i[BLK_OFFS_BITS +: IDX_BITS];

endmodule : icache_setup

`default_nettype wire

// ==== rtl/icache_pkg.sv ====
// ----------------------------------------
// Instruction cache front-end definitions
// Hit stage FSM states and bus commands
// ----------------------------------------

`default_nettype none

package icache_pkg;

  // ----------------------------------------
  // Hit stage FSM
  // ----------------------------------------
  typedef enum logic [1:0] {
    ARMED,                 // Accepting fetches, compare active
    WAIT4BIU,              // Miss issued, burst in progress
    FILL,                  // Line write plus parcel from BIU line
    FLUSH                  // Invalidate one set per cycle
  } hit_state_t;

  // ----------------------------------------
  // Commands to the bus controller
  // ----------------------------------------
  typedef enum logic {
    NOP,                   // Nothing requested
    READ_LINE              // Fetch a whole block
  } biucmd_t;

endpackage : icache_pkg

`default_nettype wire

// ==== rtl/biu_pkg.sv ====
// ----------------------------------------
// Bus interface definitions
// Word and address widths, burst FSM states
// ----------------------------------------

`default_nettype none

package biu_pkg;

  localparam int XLEN = 32;    // Data word width
  localparam int PLEN = XLEN;  // Physical address width

  // Burst read controller states
  typedef enum logic [1:0] {
    IDLE,                  // Waiting for a command
    WAIT_STB,              // Strobe out, waiting for its acknowledge
    BURST                  // Collecting data beats
  } biu_state_t;

endpackage : biu_pkg

`default_nettype wire
